//--- verilog/iq_cfg_pkg.sv
package iq_cfg_pkg;

    // Issue queue sizing
    // Depth must stay a power of two so the counters wrap on their own
    localparam int unsigned IQ_DEPTH = 8;
    localparam int unsigned IQ_IDX_LEN = 3;

    // Number of identical execution units behind the dispatcher
    localparam int unsigned NUM_EU = 3;
    // Round-robin pointer width in the result arbiter
    localparam int unsigned EU_IDX_LEN = $clog2(NUM_EU);

    // Datapath width of operands and results
    localparam int unsigned XLEN = 32;
    // Shift amount bits taken from rs2
    localparam int unsigned SHAMT_LEN = 5;

    // Sequence tag width, tags tell out-of-order results apart
    localparam int unsigned TAG_LEN = 4;

endpackage

//--- verilog/expipe_pkg.sv
package expipe_pkg;

    // ALU operations, 3-bit encoding as seen on the fetch port
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        // Signed compare, result is 1 or 0
        SLT = 3'd7
    } alu_op_t;

    // One issue queue slot
    // 3 + 4 + 32 + 32 = 71 bits
    typedef struct packed {
        alu_op_t                         op;
        logic [iq_cfg_pkg::TAG_LEN-1:0]  tag;
        // Operand values come with the instruction, no register read here
        logic [iq_cfg_pkg::XLEN-1:0]     rs1_value;
        logic [iq_cfg_pkg::XLEN-1:0]     rs2_value;
    } iq_entry_t;

    // Result leaving an execution unit
    // 4 + 32 = 36 bits
    typedef struct packed {
        logic [iq_cfg_pkg::TAG_LEN-1:0]  tag;
        logic [iq_cfg_pkg::XLEN-1:0]     value;
    } eu_result_t;

endpackage

//--- verilog/stream_if.sv
`timescale 1ns/10ps

// Valid/ready stream with a sequence tag next to the payload
// Transfer on a rising edge with valid and ready both high
interface stream_if #(
    parameter type payload_t = logic
);

    logic                           valid;
    logic                           ready;
    logic [iq_cfg_pkg::TAG_LEN-1:0] tag;
    payload_t                       data;

    // Producer side, holds valid, tag and data until accepted
    modport source (
        output valid,
        output tag,
        output data,
        input  ready
    );

    // Consumer side, ready may follow valid combinationally
    modport sink (
        input  valid,
        input  tag,
        input  data,
        output ready
    );

endinterface

//--- verilog/issue_queue.sv
`timescale 1ns/10ps

module issue_queue (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Fetch side
    input  logic                  fetch_valid_i,
    output logic                  fetch_ready_o,
    input  expipe_pkg::iq_entry_t fetch_entry_i,
    // Towards the dispatcher
    stream_if.source              issue_o
);

    // Slot storage, payload only
    expipe_pkg::iq_entry_t entry_q [iq_cfg_pkg::IQ_DEPTH];
    // One occupancy bit per slot
    logic [iq_cfg_pkg::IQ_DEPTH-1:0] valid_q;

    logic [iq_cfg_pkg::IQ_IDX_LEN-1:0] head_q;
    logic [iq_cfg_pkg::IQ_IDX_LEN-1:0] tail_q;

    logic fifo_full;
    logic push;
    logic pop;

    // All slots occupied
    assign fifo_full = &valid_q;

    // Head slot goes straight out
    assign issue_o.valid = valid_q[head_q];
    assign issue_o.data = entry_q[head_q];
    assign issue_o.tag = entry_q[head_q].tag;

    assign pop = issue_o.valid & issue_o.ready;
    // A full queue still takes a new entry when the head leaves this cycle
    assign fetch_ready_o = ~fifo_full | pop;
    assign push = fetch_valid_i & fetch_ready_o;

    // Control state, counters and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            // Drop everything, in-flight push included
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                head_q <= head_q + 1'b1;
            end
            // Comes after the pop so a full queue reuses the freed head slot
            if (push) begin
                valid_q[tail_q] <= 1'b1;
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // Slot write
    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[tail_q] <= fetch_entry_i;
        end
    end

    // Tail must point at a free slot, or at the head leaving in the same cycle
    tail_free_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        push |-> (!valid_q[tail_q] || (pop && (head_q == tail_q)))
    ) else $error("issue_queue: push into occupied slot %0d", tail_q);

endmodule

//--- verilog/issue_dispatch.sv
`timescale 1ns/10ps

module issue_dispatch (
    stream_if.sink   issue_i,
    stream_if.source eu_o [iq_cfg_pkg::NUM_EU]
);

    logic [iq_cfg_pkg::NUM_EU-1:0] eu_rdy;
    logic [iq_cfg_pkg::NUM_EU-1:0] eu_sel;
    logic [iq_cfg_pkg::NUM_EU-1:0] eu_vld;

    // Pick the lowest-indexed unit with room
    always_comb begin
        logic found;
        found = 1'b0;
        eu_sel = '0;
        for (int i = 0; i < iq_cfg_pkg::NUM_EU; i++) begin
            if (eu_rdy[i] && !found) begin
                eu_sel[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    // Only the selected unit sees valid, the rest see the same data idle
    for (genvar i = 0; i < iq_cfg_pkg::NUM_EU; i++) begin : g_eu
        assign eu_rdy[i] = eu_o[i].ready;
        assign eu_vld[i] = issue_i.valid & eu_sel[i];
        assign eu_o[i].valid = eu_vld[i];
        assign eu_o[i].tag = issue_i.tag;
        assign eu_o[i].data = issue_i.data;
    end

    // Head pops when any unit takes it
    assign issue_i.ready = |eu_sel;

    // One instruction never lands in two units
    one_unit_a: assert final ($onehot0(eu_vld))
        else $error("issue_dispatch: more than one unit valid %b", eu_vld);

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    stream_if.sink   instr_i,
    stream_if.source result_o
);

    // Stage 1, operands and operation
    logic                              s1_valid_q;
    expipe_pkg::alu_op_t               s1_op_q;
    logic [iq_cfg_pkg::TAG_LEN-1:0]    s1_tag_q;
    logic [iq_cfg_pkg::XLEN-1:0]       s1_rs1_q;
    logic [iq_cfg_pkg::XLEN-1:0]       s1_rs2_q;

    // Stage 2, finished result
    logic                              s2_valid_q;
    logic [iq_cfg_pkg::TAG_LEN-1:0]    s2_tag_q;
    logic [iq_cfg_pkg::XLEN-1:0]       s2_value_q;

    logic                              s1_ready;
    logic                              s2_ready;
    logic [iq_cfg_pkg::SHAMT_LEN-1:0]  shamt;
    logic [iq_cfg_pkg::XLEN-1:0]       alu_res;

    // A stage moves when it is empty or its content leaves this cycle
    assign s2_ready = ~s2_valid_q | result_o.ready;
    assign s1_ready = ~s1_valid_q | s2_ready;
    assign instr_i.ready = s1_ready;

    assign shamt = s1_rs2_q[iq_cfg_pkg::SHAMT_LEN-1:0];

    // ALU between the two stages
    always_comb begin
        alu_res = '0;
        case (s1_op_q)
            expipe_pkg::ADD: alu_res = s1_rs1_q + s1_rs2_q;
            expipe_pkg::SUB: alu_res = s1_rs1_q - s1_rs2_q;
            expipe_pkg::AND: alu_res = s1_rs1_q & s1_rs2_q;
            expipe_pkg::OR:  alu_res = s1_rs1_q | s1_rs2_q;
            expipe_pkg::XOR: alu_res = s1_rs1_q ^ s1_rs2_q;
            expipe_pkg::SLL: alu_res = s1_rs1_q << shamt;
            // Logical shift, zeros come in from the top
            expipe_pkg::SRL: alu_res = s1_rs1_q >> shamt;
            expipe_pkg::SLT: alu_res[0] = $signed(s1_rs1_q) < $signed(s1_rs2_q);
            default:         alu_res = '0;
        endcase
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid_q <= instr_i.valid;
            end
            if (s2_ready) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // Stage payloads, loaded only when the stage takes new content
    always_ff @(posedge clk_i) begin
        if (instr_i.valid && s1_ready) begin
            s1_op_q <= instr_i.data.op;
            s1_tag_q <= instr_i.tag;
            s1_rs1_q <= instr_i.data.rs1_value;
            s1_rs2_q <= instr_i.data.rs2_value;
        end
        if (s1_valid_q && s2_ready) begin
            s2_tag_q <= s1_tag_q;
            s2_value_q <= alu_res;
        end
    end

    assign result_o.valid = s2_valid_q;
    assign result_o.tag = s2_tag_q;
    assign result_o.data = '{tag: s2_tag_q, value: s2_value_q};

    // A stalled result stays put until the arbiter takes it
    hold_result_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        (result_o.valid && !result_o.ready) |=>
            (result_o.valid && $stable(result_o.tag) && $stable(result_o.data))
    ) else $error("exec_unit: result changed under back-pressure");

endmodule

//--- verilog/result_arbiter.sv
`timescale 1ns/10ps

module result_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    stream_if.sink                         res_i [iq_cfg_pkg::NUM_EU],
    output logic                           result_valid_o,
    input  logic                           result_ready_i,
    output logic [iq_cfg_pkg::TAG_LEN-1:0] result_tag_o,
    output logic [iq_cfg_pkg::XLEN-1:0]    result_value_o
);

    logic [iq_cfg_pkg::NUM_EU-1:0]     res_vld;
    logic [iq_cfg_pkg::TAG_LEN-1:0]    res_tag [iq_cfg_pkg::NUM_EU];
    logic [iq_cfg_pkg::XLEN-1:0]       res_val [iq_cfg_pkg::NUM_EU];

    logic [iq_cfg_pkg::NUM_EU-1:0]     grant;
    logic [iq_cfg_pkg::EU_IDX_LEN-1:0] gnt_idx;
    logic [iq_cfg_pkg::EU_IDX_LEN-1:0] ptr_q;

    for (genvar i = 0; i < iq_cfg_pkg::NUM_EU; i++) begin : g_res
        assign res_vld[i] = res_i[i].valid;
        assign res_tag[i] = res_i[i].tag;
        assign res_val[i] = res_i[i].data.value;
        // Ready goes back to the granted unit only
        assign res_i[i].ready = grant[i] & result_ready_i;
    end

    // First valid unit at or after the pointer, wrapping around
    always_comb begin
        int unsigned idx;
        grant = '0;
        gnt_idx = '0;
        for (int k = 0; k < iq_cfg_pkg::NUM_EU; k++) begin
            idx = ptr_q + k;
            if (idx >= iq_cfg_pkg::NUM_EU) begin
                idx = idx - iq_cfg_pkg::NUM_EU;
            end
            if (res_vld[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                gnt_idx = idx[iq_cfg_pkg::EU_IDX_LEN-1:0];
            end
        end
    end

    assign result_valid_o = |grant;
    assign result_tag_o = res_tag[gnt_idx];
    assign result_value_o = res_val[gnt_idx];

    // Move past the winner after a transfer
    // While stalled, park on the winner so the output does not switch units
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (result_valid_o && result_ready_i) begin
            ptr_q <= (gnt_idx == iq_cfg_pkg::NUM_EU - 1) ? '0 : gnt_idx + 1'b1;
        end else if (result_valid_o) begin
            ptr_q <= gnt_idx;
        end
    end

    grant_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant)
    ) else $error("result_arbiter: grant not one-hot %b", grant);

endmodule

//--- verilog/exec_cluster_top.sv
`timescale 1ns/10ps

module exec_cluster_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    // Instruction input from decode
    input  logic                           fetch_valid_i,
    output logic                           fetch_ready_o,
    input  expipe_pkg::alu_op_t            fetch_op_i,
    input  logic [iq_cfg_pkg::TAG_LEN-1:0] fetch_tag_i,
    input  logic [iq_cfg_pkg::XLEN-1:0]    fetch_rs1_i,
    input  logic [iq_cfg_pkg::XLEN-1:0]    fetch_rs2_i,
    // Result output, possibly out of program order
    output logic                           result_valid_o,
    input  logic                           result_ready_i,
    output logic [iq_cfg_pkg::TAG_LEN-1:0] result_tag_o,
    output logic [iq_cfg_pkg::XLEN-1:0]    result_value_o
);

    expipe_pkg::iq_entry_t fetch_entry;

    // Queue head to dispatcher
    stream_if #(.payload_t(expipe_pkg::iq_entry_t)) iq_issue ();
    // Dispatcher to each unit, and each unit to the arbiter
    stream_if #(.payload_t(expipe_pkg::iq_entry_t)) eu_instr [iq_cfg_pkg::NUM_EU] ();
    stream_if #(.payload_t(expipe_pkg::eu_result_t)) eu_result [iq_cfg_pkg::NUM_EU] ();

    assign fetch_entry = '{
        op:        fetch_op_i,
        tag:       fetch_tag_i,
        rs1_value: fetch_rs1_i,
        rs2_value: fetch_rs2_i
    };

    issue_queue i_issue_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_entry_i (fetch_entry),
        .issue_o       (iq_issue)
    );

    issue_dispatch i_issue_dispatch (
        .issue_i (iq_issue),
        .eu_o    (eu_instr)
    );

    // Identical ALU pipelines
    for (genvar i = 0; i < iq_cfg_pkg::NUM_EU; i++) begin : g_eu
        exec_unit i_exec_unit (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .flush_i  (flush_i),
            .instr_i  (eu_instr[i]),
            .result_o (eu_result[i])
        );
    end

    result_arbiter i_result_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .res_i          (eu_result),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_tag_o   (result_tag_o),
        .result_value_o (result_value_o)
    );

endmodule

//--- test/tb_exec_cluster.sv
`timescale 1ns/10ps

module tb_exec_cluster;

    localparam time CLK_PERIOD = 10ns;
    localparam time DRIVE_DLY = 1ns;
    localparam int TIMEOUT_CYC = 200;
    localparam int unsigned SEED = 32'h7180;
    localparam int NUM_TAGS = 2 ** iq_cfg_pkg::TAG_LEN;
    // Keeps a few tags spare for the allocator
    localparam int MAX_OUTSTANDING = 12;
    // Queue slots plus two stages per unit
    localparam int FILL_COUNT = iq_cfg_pkg::IQ_DEPTH + 2 * iq_cfg_pkg::NUM_EU;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic flush_i;
    logic fetch_valid_i;
    logic fetch_ready_o;
    expipe_pkg::alu_op_t fetch_op_i;
    logic [iq_cfg_pkg::TAG_LEN-1:0] fetch_tag_i;
    logic [iq_cfg_pkg::XLEN-1:0] fetch_rs1_i;
    logic [iq_cfg_pkg::XLEN-1:0] fetch_rs2_i;
    logic result_valid_o;
    logic result_ready_i;
    logic [iq_cfg_pkg::TAG_LEN-1:0] result_tag_o;
    logic [iq_cfg_pkg::XLEN-1:0] result_value_o;

    // Scoreboard indexed by tag
    logic [iq_cfg_pkg::XLEN-1:0] exp_value [NUM_TAGS];
    bit in_flight [NUM_TAGS];
    // Tags dropped by a flush, never handed out again
    bit banned [NUM_TAGS];
    int outstanding = 0;
    int next_tag = 0;
    int last_wait = 0;

    // Transfers seen on the result port, oldest first
    logic [iq_cfg_pkg::TAG_LEN-1:0] got_tag [$];
    logic [iq_cfg_pkg::XLEN-1:0] got_val [$];

    // Random result_ready_i pattern
    bit rand_ready = 1'b0;
    logic [63:0] ready_pat = '0;
    logic [5:0] pat_idx = '0;

    // Output seen stalled at the previous negedge
    bit stall_seen = 1'b0;
    logic [iq_cfg_pkg::TAG_LEN-1:0] stall_tag;
    logic [iq_cfg_pkg::XLEN-1:0] stall_val;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    exec_cluster_top i_exec_cluster_top (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_op_i     (fetch_op_i),
        .fetch_tag_i    (fetch_tag_i),
        .fetch_rs1_i    (fetch_rs1_i),
        .fetch_rs2_i    (fetch_rs2_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_tag_o   (result_tag_o),
        .result_value_o (result_value_o)
    );

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    // Reference ALU, shift amount is rs2 mod 32
    function automatic logic [31:0] alu_model(input expipe_pkg::alu_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        int sh;
        sh = b % 32;
        case (op)
            expipe_pkg::ADD: return a + b;
            expipe_pkg::SUB: return a + ~b + 32'd1;
            expipe_pkg::AND: return a & b;
            expipe_pkg::OR:  return a | b;
            expipe_pkg::XOR: return a ^ b;
            expipe_pkg::SLL: return a << sh;
            expipe_pkg::SRL: return a >> sh;
            // Differing signs decide by a's sign, else plain compare
            default: return (a[31] != b[31]) ? a[31] : (a < b);
        endcase
    endfunction

    // Result monitor, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_n_i && !flush_i) begin
            if (stall_seen) begin
                check_eq(result_valid_o, 1, "result_valid_o dropped under back-pressure");
                check_eq(result_tag_o, stall_tag, "result_tag_o changed under back-pressure");
                check_eq(result_value_o, stall_val, "result_value_o changed under back-pressure");
            end
            if (result_valid_o && result_ready_i) begin
                got_tag.push_back(result_tag_o);
                got_val.push_back(result_value_o);
            end
            stall_seen = result_valid_o && !result_ready_i;
            stall_tag = result_tag_o;
            stall_val = result_value_o;
        end else begin
            stall_seen = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        if (rand_ready) begin
            #DRIVE_DLY;
            result_ready_i = ready_pat[pat_idx];
            pat_idx = pat_idx + 1'b1;
        end
    end

    // Starts and ends 1 ns after a rising edge
    task automatic push_instr(input expipe_pkg::alu_op_t op, input logic [31:0] a,
                              input logic [31:0] b);
        int tag;
        int waited;
        tag = -1;
        for (int k = 0; k < NUM_TAGS; k++) begin
            if (tag < 0 && !in_flight[(next_tag + k) % NUM_TAGS]
                    && !banned[(next_tag + k) % NUM_TAGS]) begin
                tag = (next_tag + k) % NUM_TAGS;
            end
        end
        if (tag < 0) begin
            abort_run("no free tag left for a new instruction");
        end
        next_tag = (tag + 1) % NUM_TAGS;
        exp_value[tag] = alu_model(op, a, b);
        in_flight[tag] = 1'b1;
        outstanding++;
        fetch_valid_i = 1'b1;
        fetch_op_i = op;
        fetch_tag_i = iq_cfg_pkg::TAG_LEN'(tag);
        fetch_rs1_i = a;
        fetch_rs2_i = b;
        waited = 0;
        @(negedge clk_i);
        while (!fetch_ready_o) begin
            waited++;
            if (waited >= TIMEOUT_CYC) begin
                abort_run("timeout waiting for fetch_ready_o");
            end
            @(negedge clk_i);
        end
        last_wait = waited;
        @(posedge clk_i);
        #DRIVE_DLY;
        fetch_valid_i = 1'b0;
    endtask

    task automatic push_random();
        push_instr(expipe_pkg::alu_op_t'($urandom_range(7, 0)), $urandom(), $urandom());
    endtask

    task automatic collect_result();
        int waited;
        logic [iq_cfg_pkg::TAG_LEN-1:0] tag;
        logic [iq_cfg_pkg::XLEN-1:0] value;
        waited = 0;
        while (got_tag.size() == 0) begin
            waited++;
            if (waited > TIMEOUT_CYC) begin
                abort_run("timeout waiting for result_valid_o");
            end
            @(posedge clk_i);
            #DRIVE_DLY;
        end
        tag = got_tag.pop_front();
        value = got_val.pop_front();
        if (!in_flight[tag]) begin
            abort_run($sformatf("result with unknown or already retired tag %0d", tag));
        end
        check_eq(value, exp_value[tag], $sformatf("result value for tag %0d", tag));
        in_flight[tag] = 1'b0;
        outstanding--;
    endtask

    // No result may show up for a while
    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_eq(result_valid_o, 0, "result_valid_o high with nothing in flight");
        end
        check_eq(got_tag.size(), 0, "extra results on the result port");
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic run_random(input int count);
        for (int n = 0; n < count; n++) begin
            if (outstanding >= MAX_OUTSTANDING) begin
                collect_result();
            end
            push_random();
        end
        while (outstanding > 0) begin
            collect_result();
        end
    endtask

    // Every operation, signed SLT and shifts by 31 and above
    task automatic test_each_op();
        push_instr(expipe_pkg::ADD, 32'h7fff_ffff, 32'h0000_0001);
        push_instr(expipe_pkg::SUB, 32'h0000_0000, 32'h0000_0001);
        push_instr(expipe_pkg::AND, 32'hf0f0_1234, 32'h0ff0_ff00);
        push_instr(expipe_pkg::OR,  32'hf0f0_1234, 32'h0ff0_ff00);
        push_instr(expipe_pkg::XOR, 32'hf0f0_1234, 32'h0ff0_ff00);
        push_instr(expipe_pkg::SLL, 32'h8000_0001, 32'd31);
        push_instr(expipe_pkg::SLL, 32'h1234_5678, 32'd35);
        push_instr(expipe_pkg::SRL, 32'h8000_0000, 32'd31);
        push_instr(expipe_pkg::SRL, 32'hffff_ffff, 32'd63);
        push_instr(expipe_pkg::SLT, 32'hffff_fffb, 32'd3);
        push_instr(expipe_pkg::SLT, 32'd3, 32'hffff_fffb);
        push_instr(expipe_pkg::SLT, 32'h8000_0000, 32'h7fff_ffff);
        while (outstanding > 0) begin
            collect_result();
        end
        expect_idle(5);
    endtask

    task automatic test_back_pressure();
        result_ready_i = 1'b0;
        for (int n = 0; n < FILL_COUNT; n++) begin
            push_random();
            check_eq(last_wait, 0, "fetch_ready_o low before queue and units are full");
        end
        repeat (4) begin
            @(negedge clk_i);
            check_eq(fetch_ready_o, 0, "fetch_ready_o high with queue and units full");
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        result_ready_i = 1'b1;
        while (outstanding > 0) begin
            collect_result();
        end
        expect_idle(5);
    endtask

    task automatic test_random_ready();
        ready_pat = {$urandom(), $urandom()};
        rand_ready = 1'b1;
        run_random(30);
        rand_ready = 1'b0;
        @(posedge clk_i);
        #DRIVE_DLY;
        result_ready_i = 1'b1;
        expect_idle(5);
    endtask

    task automatic test_flush();
        result_ready_i = 1'b0;
        // Units and queue both full, so the flush has to empty every slot
        repeat (FILL_COUNT) push_random();
        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
        check_eq(fetch_ready_o, 0, "fetch_ready_o high with queue and units full");
        flush_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        flush_i = 1'b0;
        check_eq(result_valid_o, 0, "result_valid_o after flush");
        check_eq(fetch_ready_o, 1, "fetch_ready_o after flush");
        // Flushed tags must never come back
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (in_flight[t]) begin
                banned[t] = 1'b1;
                in_flight[t] = 1'b0;
            end
        end
        outstanding = 0;
        result_ready_i = 1'b1;
        expect_idle(6);
        // Few tags are left unbanned, so issue and retire one at a time
        repeat (6) begin
            push_random();
            collect_result();
        end
        expect_idle(5);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_op_i = expipe_pkg::ADD;
        fetch_tag_i = '0;
        fetch_rs1_i = '0;
        fetch_rs2_i = '0;
        result_ready_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        check_eq(fetch_ready_o, 1, "fetch_ready_o after reset");
        check_eq(result_valid_o, 0, "result_valid_o after reset");
        test_each_op();
        run_random(40);
        expect_idle(5);
        test_back_pressure();
        test_random_ready();
        test_flush();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- vlog.f
verilog/iq_cfg_pkg.sv
verilog/expipe_pkg.sv
verilog/stream_if.sv
verilog/issue_queue.sv
verilog/issue_dispatch.sv
verilog/exec_unit.sv
verilog/result_arbiter.sv
verilog/exec_cluster_top.sv
test/tb_exec_cluster.sv
